//--- src/mmu_pkg.sv
//=============================
// shared MMU types, bus register map and field positions;
// blocks use them by scoped name
//=============================
`default_nettype none

package mmu_pkg;

typedef logic [15:0] word_t;        // one bus word
typedef logic [15:0] vaddr_t;       // virtual address
typedef logic [21:0] paddr_t;       // physical address
typedef logic [3:0]  page_idx_t;    // {kernel set, page 2:0}

// what a bus address selects
typedef enum logic [2:0]
{
   sel_none,
   sel_sr0,
   sel_sr3,
   sel_par,
   sel_pdr
} reg_sel_e;

localparam int unsigned num_pages  = 16;   // 8 kernel + 8 user pairs
localparam int unsigned reg_addr_w = 13;   // low bits of the I/O page address
localparam int unsigned plf_w      = 7;    // page length and block number width
localparam int unsigned block_lsb  = 6;    // 64-byte blocks

localparam logic [reg_addr_w-1:0] sr0_addr  = 13'o17572;
localparam logic [reg_addr_w-1:0] sr3_addr  = 13'o12516;
localparam logic [reg_addr_w-1:0] kpdr_base = 13'o12300;
localparam logic [reg_addr_w-1:0] kpar_base = 13'o12340;
localparam logic [reg_addr_w-1:0] updr_base = 13'o17600;
localparam logic [reg_addr_w-1:0] upar_base = 13'o17640;

// page descriptor fields
localparam word_t       pdr_rd_mask = 16'o077516;
localparam int unsigned pdr_plf_lsb = 8;    // plf in 14:8
localparam int unsigned pdr_w_bit   = 6;    // dirty page
localparam int unsigned pdr_ed_bit  = 3;    // expansion downwards
localparam int unsigned pdr_acf_wr  = 2;
localparam int unsigned pdr_acf_res = 1;

// status register 0
localparam int unsigned sr0_nr_bit   = 15;
localparam int unsigned sr0_le_bit   = 14;
localparam int unsigned sr0_ro_bit   = 13;
localparam int unsigned sr0_mode_lsb = 5;   // mode in 6:5
localparam int unsigned sr0_page_lsb = 1;   // page in 3:1
localparam int unsigned sr0_en_bit   = 0;

// status register 3
localparam int unsigned sr3_22bit_bit = 4;
localparam int unsigned sr3_umap_bit  = 5;

endpackage

`default_nettype wire

//--- src/mmu_regs.sv
//=============================
// CPU side of the MMU: bus address decode, SR0/SR3
// and the registered read data path
//=============================
`timescale 1ns/1ps
`default_nettype none

module mmu_regs
(
   input  logic                           clk,
   input  logic                           sr_rst,
   input  logic                           reg_wr,       // word write strobe
   input  logic                           reg_rd,       // read strobe
   input  logic [mmu_pkg::reg_addr_w-1:0] reg_addr,
   input  mmu_pkg::word_t                 reg_wdata,
   input  mmu_pkg::word_t                 par_rd,
   input  mmu_pkg::word_t                 pdr_rd,
   input  logic                           xlat_done,
   input  logic                           abort_nr,
   input  logic                           abort_le,
   input  logic                           abort_ro,
   input  mmu_pkg::page_idx_t             abort_idx,    // stage 1 page of addr_xlat
   output mmu_pkg::word_t                 reg_rdata,
   output logic                           reg_ack,
   output logic                           par_we,
   output logic                           pdr_we,
   output mmu_pkg::page_idx_t             reg_idx,
   output mmu_pkg::word_t                 wdata,
   output logic                           mmu_en,
   output logic                           en_22
);

mmu_pkg::reg_sel_e   sel;
logic                kern_set;
mmu_pkg::page_idx_t  done_idx;
mmu_pkg::word_t      sr0;
mmu_pkg::word_t      sr0_nxt;
mmu_pkg::word_t      sr3;
mmu_pkg::word_t      rd_mux;
logic                frozen;
logic                new_abort;

always_comb
begin
   sel      = mmu_pkg::sel_none;
   kern_set = 1'b0;
   if (reg_addr[12:1] == mmu_pkg::sr0_addr[12:1])
      sel = mmu_pkg::sel_sr0;
   else if (reg_addr[12:1] == mmu_pkg::sr3_addr[12:1])
      sel = mmu_pkg::sel_sr3;
   else if (reg_addr[12:4] == mmu_pkg::kpdr_base[12:4])
   begin
      sel      = mmu_pkg::sel_pdr;
      kern_set = 1'b1;
   end
   else if (reg_addr[12:4] == mmu_pkg::kpar_base[12:4])
   begin
      sel      = mmu_pkg::sel_par;
      kern_set = 1'b1;
   end
   else if (reg_addr[12:4] == mmu_pkg::updr_base[12:4])
      sel = mmu_pkg::sel_pdr;
   else if (reg_addr[12:4] == mmu_pkg::upar_base[12:4])
      sel = mmu_pkg::sel_par;
end

assign reg_idx = {kern_set, reg_addr[3:1]};
assign wdata   = reg_wdata;
assign par_we  = reg_wr & (sel == mmu_pkg::sel_par);
assign pdr_we  = reg_wr & (sel == mmu_pkg::sel_pdr);

always_ff @(posedge clk)
   done_idx <= abort_idx;                    // w_idx runs a cycle ahead of xlat_done

assign frozen = sr0[mmu_pkg::sr0_nr_bit] | sr0[mmu_pkg::sr0_le_bit]
              | sr0[mmu_pkg::sr0_ro_bit];
assign new_abort = xlat_done & (abort_nr | abort_le | abort_ro) & ~frozen;

// next SR0, the read path also sees a pending abort through it
always_comb
begin
   sr0_nxt = sr0;
   if (new_abort)
   begin
      sr0_nxt[mmu_pkg::sr0_nr_bit] = abort_nr;
      sr0_nxt[mmu_pkg::sr0_le_bit] = abort_le;
      sr0_nxt[mmu_pkg::sr0_ro_bit] = abort_ro;
      sr0_nxt[mmu_pkg::sr0_page_lsb +: 3] = done_idx[2:0];
      sr0_nxt[mmu_pkg::sr0_mode_lsb +: 2] = done_idx[3] ? 2'b00 : 2'b11;   // 11 user
   end
   if (reg_wr & (sel == mmu_pkg::sel_sr0))
   begin
      sr0_nxt[mmu_pkg::sr0_nr_bit] = reg_wdata[mmu_pkg::sr0_nr_bit];
      sr0_nxt[mmu_pkg::sr0_le_bit] = reg_wdata[mmu_pkg::sr0_le_bit];
      sr0_nxt[mmu_pkg::sr0_ro_bit] = reg_wdata[mmu_pkg::sr0_ro_bit];
      sr0_nxt[mmu_pkg::sr0_en_bit] = reg_wdata[mmu_pkg::sr0_en_bit];
   end
end

always_ff @(posedge clk)
begin
   if (sr_rst)
   begin
      sr0 <= '0;
      sr3 <= '0;
   end
   else
   begin
      sr0 <= sr0_nxt;
      if (reg_wr & (sel == mmu_pkg::sel_sr3))
      begin
         sr3[mmu_pkg::sr3_22bit_bit] <= reg_wdata[mmu_pkg::sr3_22bit_bit];
         sr3[mmu_pkg::sr3_umap_bit]  <= reg_wdata[mmu_pkg::sr3_umap_bit];   // stored only
      end
   end
end

always_comb
begin
   case (sel)
      mmu_pkg::sel_sr0: rd_mux = sr0_nxt;
      mmu_pkg::sel_sr3: rd_mux = sr3;
      mmu_pkg::sel_par: rd_mux = par_rd;
      mmu_pkg::sel_pdr: rd_mux = pdr_rd & mmu_pkg::pdr_rd_mask;
      default:          rd_mux = '0;
   endcase
end

always_ff @(posedge clk)
begin
   if (reg_rd)
      reg_rdata <= rd_mux;
end

always_ff @(posedge clk)
begin
   if (sr_rst)
      reg_ack <= 1'b0;
   else
      reg_ack <= (reg_wr | reg_rd) & (sel != mmu_pkg::sel_none);
end

assign mmu_en = sr0[mmu_pkg::sr0_en_bit];
assign en_22  = sr3[mmu_pkg::sr3_22bit_bit];

endmodule

`default_nettype wire

//--- src/page_file.sv
//=============================
// 16 PAR/PDR pairs, one CPU port and one lookup port,
// plus the W (dirty page) bits
//=============================
`timescale 1ns/1ps
`default_nettype none

module page_file
(
   input  logic                clk,
   input  logic                par_we,
   input  logic                pdr_we,
   input  mmu_pkg::page_idx_t  reg_idx,     // CPU port page
   input  mmu_pkg::word_t      wdata,
   input  mmu_pkg::page_idx_t  look_idx,    // translation lookup page
   input  logic                w_set,
   input  mmu_pkg::page_idx_t  w_idx,
   output mmu_pkg::word_t      par_rd,
   output mmu_pkg::word_t      pdr_rd,
   output mmu_pkg::word_t      look_par,
   output mmu_pkg::word_t      look_pdr
);

mmu_pkg::word_t                par [mmu_pkg::num_pages];
mmu_pkg::word_t                pdr [mmu_pkg::num_pages];
logic [mmu_pkg::num_pages-1:0] w_bit;

always_ff @(posedge clk)
begin
   if (par_we)
      par[reg_idx] <= wdata;
   if (pdr_we)                               // plf, ed and acf only
      pdr[reg_idx] <= wdata & mmu_pkg::pdr_rd_mask
                    & ~(mmu_pkg::word_t'(1) << mmu_pkg::pdr_w_bit);
end

// a CPU write to either register of the pair wins over w_set
always_ff @(posedge clk)
begin
   if (w_set)
      w_bit[w_idx] <= 1'b1;
   if (par_we | pdr_we)
      w_bit[reg_idx] <= 1'b0;
end

always_comb
begin
   par_rd = par[reg_idx];
   pdr_rd = pdr[reg_idx];
   pdr_rd[mmu_pkg::pdr_w_bit] = w_bit[reg_idx];
end

always_comb
begin
   look_par = par[look_idx];
   look_pdr = pdr[look_idx];
end

endmodule

`default_nettype wire

//--- src/addr_xlat.sv
//=============================
// two-stage virtual to physical translation with relocation
// adder, page limit check and access aborts
//=============================
`timescale 1ns/1ps
`default_nettype none

module addr_xlat
(
   input  logic                clk,
   input  logic                sr_rst,
   input  logic                xlat_req,
   input  logic                xlat_write,
   input  logic                user_mode,
   input  mmu_pkg::vaddr_t     va,
   input  logic                mmu_en,      // SR0 bit 0
   input  logic                en_22,       // SR3 22-bit mode
   input  mmu_pkg::word_t      look_par,
   input  mmu_pkg::word_t      look_pdr,
   output mmu_pkg::page_idx_t  look_idx,
   output logic                xlat_done,
   output mmu_pkg::paddr_t     pa,
   output logic                abort_nr,
   output logic                abort_le,
   output logic                abort_ro,
   output logic                w_set,
   output mmu_pkg::page_idx_t  w_idx
);

logic                       s1_vld;
logic                       s1_write;
mmu_pkg::page_idx_t         s1_idx;
mmu_pkg::word_t             s1_par;
mmu_pkg::word_t             s1_pdr;
mmu_pkg::vaddr_t            s1_va;

logic [mmu_pkg::plf_w-1:0]  blk;
logic [mmu_pkg::plf_w-1:0]  plf;
mmu_pkg::paddr_t            sum;
mmu_pkg::paddr_t            pa_nxt;
logic                       lim_err;
logic                       non_res;
logic                       rd_only;
logic                       any_err;

assign look_idx = {~user_mode, va[15:13]};   // kernel set has the top bit

// stage 1: request and looked up page registers
always_ff @(posedge clk)
begin
   if (sr_rst)
      s1_vld <= 1'b0;
   else
      s1_vld <= xlat_req;
end

always_ff @(posedge clk)
begin
   s1_write <= xlat_write;
   s1_idx   <= look_idx;
   s1_par   <= look_par;
   s1_pdr   <= look_pdr;
   s1_va    <= va;
end

// stage 2: relocation and checks
always_comb
begin
   blk = s1_va[mmu_pkg::block_lsb +: mmu_pkg::plf_w];
   plf = s1_pdr[mmu_pkg::pdr_plf_lsb +: mmu_pkg::plf_w];
   sum = (mmu_pkg::paddr_t'(s1_par) << mmu_pkg::block_lsb)
       + mmu_pkg::paddr_t'(s1_va[mmu_pkg::block_lsb+mmu_pkg::plf_w-1:0]);
   if (!en_22)
      sum[21:18] = 4'b0000;                  // 18-bit mode
   if (s1_pdr[mmu_pkg::pdr_ed_bit])
      lim_err = blk < plf;                   // page grows down
   else
      lim_err = blk > plf;
   non_res = ~s1_pdr[mmu_pkg::pdr_acf_res];
   rd_only = s1_pdr[mmu_pkg::pdr_acf_res] & ~s1_pdr[mmu_pkg::pdr_acf_wr] & s1_write;
   any_err = lim_err | non_res | rd_only;
   pa_nxt  = mmu_en ? sum : mmu_pkg::paddr_t'(s1_va);
end

// dirty bit goes in at the same edge as the result
assign w_set = s1_vld & mmu_en & s1_write & ~any_err;
assign w_idx = s1_idx;

always_ff @(posedge clk)
begin
   if (sr_rst)
   begin
      xlat_done <= 1'b0;
      abort_nr  <= 1'b0;
      abort_le  <= 1'b0;
      abort_ro  <= 1'b0;
   end
   else
   begin
      xlat_done <= s1_vld;
      abort_nr  <= s1_vld & mmu_en & non_res;
      abort_le  <= s1_vld & mmu_en & lim_err;
      abort_ro  <= s1_vld & mmu_en & rd_only;
   end
end

always_ff @(posedge clk)
   pa <= pa_nxt;

endmodule

`default_nettype wire

//--- src/dc304_mmu.sv
//=============================
// DC304 memory management top level, connects the register
// block, the page file and the translation pipeline
//=============================
`timescale 1ns/1ps
`default_nettype none

module dc304_mmu
(
   input  logic                           clk,
   input  logic                           sr_rst,
   input  logic                           reg_wr,
   input  logic                           reg_rd,
   input  logic [mmu_pkg::reg_addr_w-1:0] reg_addr,
   input  mmu_pkg::word_t                 reg_wdata,
   output mmu_pkg::word_t                 reg_rdata,
   output logic                           reg_ack,
   input  logic                           xlat_req,
   input  mmu_pkg::vaddr_t                va,
   input  logic                           xlat_write,
   input  logic                           user_mode,
   output logic                           xlat_done,
   output mmu_pkg::paddr_t                pa,
   output logic                           abort_nr,
   output logic                           abort_le,
   output logic                           abort_ro
);

logic                par_we;
logic                pdr_we;
mmu_pkg::page_idx_t  reg_idx;
mmu_pkg::word_t      wdata;
mmu_pkg::word_t      par_rd;
mmu_pkg::word_t      pdr_rd;
mmu_pkg::page_idx_t  look_idx;
mmu_pkg::word_t      look_par;
mmu_pkg::word_t      look_pdr;
logic                w_set;
mmu_pkg::page_idx_t  w_idx;
logic                mmu_en;
logic                en_22;

mmu_regs u_regs
(
   .clk, .sr_rst, .reg_wr, .reg_rd, .reg_addr, .reg_wdata,
   .par_rd, .pdr_rd,
   .xlat_done, .abort_nr, .abort_le, .abort_ro,
   .abort_idx  (w_idx),                      // page of the translation in stage 1
   .reg_rdata, .reg_ack,
   .par_we, .pdr_we, .reg_idx, .wdata,
   .mmu_en, .en_22
);

page_file u_pages
(
   .clk, .par_we, .pdr_we, .reg_idx, .wdata,
   .look_idx, .w_set, .w_idx,
   .par_rd, .pdr_rd, .look_par, .look_pdr
);

addr_xlat u_xlat
(
   .clk, .sr_rst, .xlat_req, .xlat_write, .user_mode, .va,
   .mmu_en, .en_22, .look_par, .look_pdr,
   .look_idx, .xlat_done, .pa,
   .abort_nr, .abort_le, .abort_ro,
   .w_set, .w_idx
);

endmodule

`default_nettype wire

//--- verif/tb_dc304_ref.svh
//==============================
// reference translation, random source and compare tasks,
// included inside the MMU testbench top
//==============================
`ifndef TB_DC304_REF_SVH
`define TB_DC304_REF_SVH

function automatic logic [31:0] xorshift32(input logic [31:0] s);
   logic [31:0] x;
   x = s;
   x = x ^ (x << 13);
   x = x ^ (x >> 17);
   x = x ^ (x << 5);
   return x;
endfunction

function automatic logic [31:0] next_rand();
   rng = xorshift32(rng);
   return rng;
endfunction

// expected {nr, le, ro, pa} from the model registers
function automatic logic [24:0] xlat_ref
(
   input mmu_pkg::vaddr_t v,
   input logic            wr,
   input logic            usr
);
   logic [3:0]  idx;
   logic [6:0]  blk;
   logic [6:0]  plf;
   logic [21:0] addr;
   logic        nr;
   logic        le;
   logic        ro;
   idx = {~usr, v[15:13]};
   if (!sr0_m[0])
      return {3'b000, 6'b000000, v};          // mapping off
   blk  = v[12:6];
   plf  = pdr_m[idx][14:8];
   addr = {par_m[idx], 6'b000000} + {9'b0, v[12:0]};
   if (!sr3_m[4])
      addr[21:18] = 4'b0000;
   le = pdr_m[idx][3] ? (blk < plf) : (blk > plf);
   nr = !pdr_m[idx][1];
   ro = pdr_m[idx][1] && !pdr_m[idx][2] && wr;
   return {nr, le, ro, addr};
endfunction

task automatic check_word(input string what, input mmu_pkg::word_t exp, input mmu_pkg::word_t act);
   if (act !== exp)
   begin
      $display("FAILED %s %s: expected %o, actual %o", test_name, what, exp, act);
      fail_stop();
   end
endtask

task automatic check_paddr(input string what, input mmu_pkg::paddr_t exp, input mmu_pkg::paddr_t act);
   if (act !== exp)
   begin
      $display("FAILED %s %s: expected %o, actual %o", test_name, what, exp, act);
      fail_stop();
   end
endtask

task automatic check_flag(input string what, input logic exp, input logic act);
   if (act !== exp)
   begin
      $display("FAILED %s %s: expected %b, actual %b", test_name, what, exp, act);
      fail_stop();
   end
endtask

`endif

//--- verif/tb_dc304.sv
//==============================
// testbench for the DC304 MMU top, checks register access,
// translation, aborts, SR0 freeze and the W bit
//==============================
`timescale 1ns/1ps
`default_nettype none

module tb_dc304;

logic                           clk = 1'b0;
logic                           sr_rst;
logic                           reg_wr;
logic                           reg_rd;
logic [mmu_pkg::reg_addr_w-1:0] reg_addr;
mmu_pkg::word_t                 reg_wdata;
mmu_pkg::word_t                 reg_rdata;
logic                           reg_ack;
logic                           xlat_req;
mmu_pkg::vaddr_t                va;
logic                           xlat_write;
logic                           user_mode;
logic                           xlat_done;
mmu_pkg::paddr_t                pa;
logic                           abort_nr;
logic                           abort_le;
logic                           abort_ro;

mmu_pkg::word_t par_m [16];             // model of the programmed state
mmu_pkg::word_t pdr_m [16];
logic [15:0]    w_m;
mmu_pkg::word_t sr0_m;
mmu_pkg::word_t sr3_m;
logic [31:0]    rng = 32'd76719;
int             cyc = 0;
string          test_name = "reset";
logic [24:0]    exp_q [$];              // {nr, le, ro, pa}
int             due_q [$];              // cycle of the expected xlat_done

task automatic fail_stop();
   $display("TEST FAILED");
   $fatal(1);
endtask

`include "tb_dc304_ref.svh"

dc304_mmu UUT
(
   .clk, .sr_rst, .reg_wr, .reg_rd, .reg_addr, .reg_wdata, .reg_rdata, .reg_ack,
   .xlat_req, .va, .xlat_write, .user_mode,
   .xlat_done, .pa, .abort_nr, .abort_le, .abort_ro
);

always #50 clk = ~clk;

always @(posedge clk)
   cyc <= cyc + 1;

function automatic logic [mmu_pkg::reg_addr_w-1:0] page_addr(input logic [3:0] idx,
                                                             input logic is_par);
   logic [mmu_pkg::reg_addr_w-1:0] base;
   if (is_par)
      base = idx[3] ? mmu_pkg::kpar_base : mmu_pkg::upar_base;
   else
      base = idx[3] ? mmu_pkg::kpdr_base : mmu_pkg::updr_base;
   return base | {idx[2:0], 1'b0};
endfunction

function automatic mmu_pkg::word_t pdr_exp(input logic [3:0] idx);
   return pdr_m[idx] | {9'b0, w_m[idx], 6'b000000};
endfunction

// strobe was driven, drop it and expect the ack one cycle later
task automatic wait_ack(input string what);
   int n;
   n = 0;
   @(posedge clk);
   #1;
   reg_wr = 1'b0;
   reg_rd = 1'b0;
   while (reg_ack !== 1'b1)
   begin
      if (n == 8)
      begin
         $display("no reg_ack for %s in test %s", what, test_name);
         fail_stop();
      end
      @(posedge clk);
      #1;
      n++;
   end
   check_flag({what, " ack after one cycle"}, 1'b1, n == 0);
endtask

task automatic bus_write(input logic [mmu_pkg::reg_addr_w-1:0] addr, input mmu_pkg::word_t data);
   reg_addr  = addr;
   reg_wdata = data;
   reg_wr    = 1'b1;
   wait_ack("write");
endtask

task automatic bus_read_check(input logic [mmu_pkg::reg_addr_w-1:0] addr,
                              input mmu_pkg::word_t exp, input string what);
   reg_addr = addr;
   reg_rd   = 1'b1;
   wait_ack(what);
   check_word(what, exp, reg_rdata);
endtask

task automatic bus_unmapped(input logic [mmu_pkg::reg_addr_w-1:0] addr, input logic rd);
   int n;
   reg_addr  = addr;
   reg_wdata = 16'hffff;
   reg_wr    = ~rd;
   reg_rd    = rd;
   @(posedge clk);
   #1;
   reg_wr = 1'b0;
   reg_rd = 1'b0;
   for (n = 0; n < 3; n++)
   begin
      check_flag("unmapped reg_ack", 1'b0, reg_ack);
      @(posedge clk);
      #1;
   end
endtask

task automatic write_par(input logic [3:0] idx, input mmu_pkg::word_t data);
   par_m[idx] = data;
   w_m[idx]   = 1'b0;
   bus_write(page_addr(idx, 1'b1), data);
endtask

task automatic write_pdr(input logic [3:0] idx, input mmu_pkg::word_t data);
   pdr_m[idx] = data & 16'o077416;      // plf, ed, acf
   w_m[idx]   = 1'b0;
   bus_write(page_addr(idx, 1'b0), data);
endtask

task automatic write_sr0(input mmu_pkg::word_t data);
   sr0_m = (sr0_m & ~16'o160001) | (data & 16'o160001);
   bus_write(mmu_pkg::sr0_addr, data);
endtask

task automatic write_sr3(input mmu_pkg::word_t data);
   sr3_m = data & 16'o000060;
   bus_write(mmu_pkg::sr3_addr, data);
endtask

// one request, model W bit and SR0 move at issue since results return in order
task automatic xlat_issue(input mmu_pkg::vaddr_t v, input logic wr, input logic usr);
   logic [24:0] exp_v;
   logic [3:0]  idx;
   exp_v = xlat_ref(v, wr, usr);
   idx   = {~usr, v[15:13]};
   if (sr0_m[0] && wr && exp_v[24:22] == 3'b000)
      w_m[idx] = 1'b1;
   if (exp_v[24:22] != 3'b000 && sr0_m[15:13] == 3'b000)
   begin
      sr0_m[15:13] = exp_v[24:22];
      sr0_m[6:5]   = usr ? 2'b11 : 2'b00;
      sr0_m[3:1]   = v[15:13];
   end
   exp_q.push_back(exp_v);
   due_q.push_back(cyc + 2);
   va         = v;
   xlat_write = wr;
   user_mode  = usr;
   xlat_req   = 1'b1;
   @(posedge clk);
   #1;
   xlat_req = 1'b0;
endtask

task automatic drain();
   int n;
   n = 0;
   while (due_q.size() != 0)
   begin
      if (n == 10)
      begin
         $display("translations did not complete in test %s", test_name);
         fail_stop();
      end
      @(posedge clk);
      #1;
      n++;
   end
   @(posedge clk);                      // SR0 settles one edge after xlat_done
   #1;
endtask

always @(negedge clk)
begin : check_results
   logic [24:0] exp_v;
   if (due_q.size() != 0 && due_q[0] < cyc)
   begin
      $display("xlat_done missing for a request in test %s", test_name);
      fail_stop();
   end
   if (xlat_done === 1'b1)
   begin
      if (due_q.size() == 0 || due_q[0] != cyc)
      begin
         $display("xlat_done with no request due in test %s", test_name);
         fail_stop();
      end
      exp_v = exp_q.pop_front();
      due_q.delete(0);
      check_paddr("pa", exp_v[21:0], pa);
      check_flag("abort_nr", exp_v[24], abort_nr);
      check_flag("abort_le", exp_v[23], abort_le);
      check_flag("abort_ro", exp_v[22], abort_ro);
   end
   else
   begin
      check_flag("idle abort_nr", 1'b0, abort_nr);
      check_flag("idle abort_le", 1'b0, abort_le);
      check_flag("idle abort_ro", 1'b0, abort_ro);
   end
end

initial
begin
   int          i;
   int          e;
   logic [31:0] r;
   sr_rst     = 1'b1;
   reg_wr     = 1'b0;
   reg_rd     = 1'b0;
   reg_addr   = '0;
   reg_wdata  = '0;
   xlat_req   = 1'b0;
   va         = '0;
   xlat_write = 1'b0;
   user_mode  = 1'b0;
   sr0_m      = '0;
   sr3_m      = '0;
   w_m        = '0;
   repeat (5) @(posedge clk);
   #1;
   sr_rst = 1'b0;
   check_flag("reg_ack", 1'b0, reg_ack);
   check_flag("xlat_done", 1'b0, xlat_done);
   bus_read_check(mmu_pkg::sr0_addr, 16'o0, "sr0");
   bus_read_check(mmu_pkg::sr3_addr, 16'o0, "sr3");

   test_name = "readback";
   for (i = 0; i < 16; i++)
   begin
      r = next_rand();
      write_par(i[3:0], r[15:0]);
      write_pdr(i[3:0], r[31:16]);
   end
   for (i = 0; i < 24; i++)
   begin
      r = next_rand();
      if (r[0])
         write_par(r[4:1], r[31:16]);
      else
         write_pdr(r[4:1], r[31:16]);
   end
   bus_unmapped(13'o00000, 1'b0);
   bus_unmapped(13'o12320, 1'b1);
   bus_unmapped(13'o17574, 1'b0);
   bus_unmapped(13'o12360, 1'b1);
   for (i = 0; i < 16; i++)
   begin
      bus_read_check(page_addr(i[3:0], 1'b1), par_m[i], "par");
      bus_read_check(page_addr(i[3:0], 1'b0), pdr_exp(i[3:0]), "pdr");
   end
   r = next_rand();
   write_sr3(r[15:0]);
   bus_read_check(mmu_pkg::sr3_addr, sr3_m, "sr3");
   write_sr0(r[31:16]);
   bus_read_check(mmu_pkg::sr0_addr, sr0_m, "sr0");
   write_sr0(16'o0);

   test_name = "disabled";
   for (i = 0; i < 24; i++)
   begin
      r = next_rand();
      xlat_issue(r[15:0], r[16], r[17]);
      if (r[18])                        // otherwise back to back
      begin
         @(posedge clk);
         #1;
      end
   end
   drain();

   test_name = "relocation";
   for (i = 0; i < 16; i++)
   begin
      r = next_rand();
      write_pdr(i[3:0], 16'o077406);    // full length, resident, writable
      write_par(i[3:0], r[15:0]);
   end
   write_sr0(16'o1);
   for (e = 0; e < 2; e++)
   begin
      write_sr3(e[0] ? 16'o20 : 16'o0);
      for (i = 0; i < 32; i++)
      begin
         r = next_rand();
         xlat_issue(r[15:0], r[16], r[17]);
      end
      drain();
   end

   test_name = "aborts";
   for (i = 0; i < 16; i++)
   begin
      r = next_rand();
      write_pdr(i[3:0], r[15:0]);
   end
   for (i = 0; i < 48; i++)
   begin
      r = next_rand();
      xlat_issue(r[15:0], r[16], r[17]);
   end
   drain();
   bus_read_check(mmu_pkg::sr0_addr, sr0_m, "sr0");
   for (i = 0; i < 16; i++)
      bus_read_check(page_addr(i[3:0], 1'b0), pdr_exp(i[3:0]), "pdr");

   test_name = "sr0 freeze";
   write_sr0(16'o1);
   write_pdr(4'hb, 16'o0);              // kernel page 3 non-resident
   write_pdr(4'h5, 16'o077402);         // user page 5 read-only
   xlat_issue(16'h6000, 1'b0, 1'b0);
   xlat_issue(16'ha000, 1'b1, 1'b1);
   drain();
   bus_read_check(mmu_pkg::sr0_addr, 16'o100007, "first abort");
   write_sr0(16'o1);
   xlat_issue(16'ha040, 1'b1, 1'b1);
   drain();
   bus_read_check(mmu_pkg::sr0_addr, 16'o020153, "rearmed abort");

   test_name = "w bit";
   r = next_rand();
   write_pdr(4'h2, 16'o077406);
   write_par(4'h2, r[15:0]);
   bus_read_check(page_addr(4'h2, 1'b0), 16'o077406, "pdr clean");
   xlat_issue(16'h4010, 1'b0, 1'b1);
   drain();
   bus_read_check(page_addr(4'h2, 1'b0), 16'o077406, "pdr after read");
   xlat_issue(16'h4010, 1'b1, 1'b1);
   drain();
   bus_read_check(page_addr(4'h2, 1'b0), 16'o077506, "pdr after write");
   write_par(4'h2, r[31:16]);
   bus_read_check(page_addr(4'h2, 1'b0), 16'o077406, "pdr after par write");

   $display("TEST OK");
   $finish;
end

endmodule

`default_nettype wire

//--- files.f
+incdir+verif
src/mmu_pkg.sv
src/mmu_regs.sv
src/page_file.sv
src/addr_xlat.sv
src/dc304_mmu.sv
verif/tb_dc304.sv
